// ==== source/bch_settings.svh ====
`ifndef BCH_SETTINGS_SVH
`define BCH_SETTINGS_SVH

// BCH(31,21), t = 2, over GF(2^5)
`define BCH_N 31 // Codeword length
`define BCH_K 21 // Data bits per message
`define BCH_ECC_BITS 10 // Parity bits

// x^10+x^9+x^8+x^6+x^5+x^3+1
`define BCH_GEN_POLY 11'h769

// Field degree, also the width of the cycle counter
`define BCH_M 5

// x^5+x^2+1, primitive so the counter walks all 31 nonzero states
`define BCH_CNT_POLY 6'h25

`define BCH_IN_CREDITS 4 // Input buffer depth
`define BCH_OUT_CREDITS_MAX 8 // Most credits the receiver grants ahead

`endif

// ==== source/bch_pkg.sv ====
`include "bch_settings.svh"

package bch_pkg;

	typedef logic [`BCH_ECC_BITS-1:0] parity_t;
	typedef logic [`BCH_M-1:0] count_t;
	typedef logic [3:0] credit_t; // Holds 0..BCH_OUT_CREDITS_MAX
	typedef logic [1:0] word_t; // Buffer entry {start, bit}

	typedef enum logic [1:0] {
		IDLE,
		DATA,
		PARITY
	} enc_phase_t;

	// Counter state right after a clear
	localparam count_t CNT_SEED = count_t'(1);

	// One Galois step of the cycle counter
	function automatic count_t count_step(input count_t c);
		count_t n;
		n = {c[`BCH_M-2:0], 1'b0};
		if (c[`BCH_M-1]) begin
			n = n ^ count_t'(`BCH_CNT_POLY);
		end
		return n;
	endfunction

endpackage

// ==== source/lfsr_counter.sv ====
`timescale 1ns/1ps

module lfsr_counter (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            clear,   // Back to the seed
	input  logic            advance, // One step
	output bch_pkg::count_t count
);

	bch_pkg::count_t state;

	// A maximal-length sequence stands in for a binary counter.
	// The owner compares against precomputed states instead of integers,
	// so no carry chain is needed
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= bch_pkg::CNT_SEED;
		end else if (clear) begin
			state <= bch_pkg::CNT_SEED;
		end else if (advance) begin
			state <= bch_pkg::count_step(state);
		end
	end

	assign count = state;

endmodule

// ==== source/lfsr_term.sv ====
`timescale 1ns/1ps
`include "bch_settings.svh"

module lfsr_term #(
	parameter int WIDTH = 1
) (
	input  logic [WIDTH-1:0] in_word, // in_word[WIDTH-1] is shifted in first
	output bch_pkg::parity_t terms
);

	// Feedback taps, the x^10 term is implicit
	localparam bch_pkg::parity_t POLY = bch_pkg::parity_t'(`BCH_GEN_POLY);

	// Register change caused by a feedback bit followed by j more shifts
	function automatic bch_pkg::parity_t column(input int j);
		bch_pkg::parity_t r;
		r = POLY;
		for (int i = 0; i < j; i++) begin
			if (r[`BCH_ECC_BITS-1]) begin
				r = {r[`BCH_ECC_BITS-2:0], 1'b0} ^ POLY;
			end else begin
				r = {r[`BCH_ECC_BITS-2:0], 1'b0};
			end
		end
		return r;
	endfunction

	// One XOR tree per parity bit
	for (genvar b = 0; b < `BCH_ECC_BITS; b++) begin : g_bit
		logic [WIDTH-1:0] sel;

		for (genvar j = 0; j < WIDTH; j++) begin : g_col
			localparam bch_pkg::parity_t COL = column(j);

			assign sel[j] = in_word[j] & COL[b];
		end

		assign terms[b] = ^sel;
	end

endmodule

// ==== source/bch_encode.sv ====
`timescale 1ns/1ps
`include "bch_settings.svh"

module bch_encode (
	input  logic clk,
	input  logic rst_n,
	input  logic ce,         // Advance one codeword bit
	input  logic fifo_valid,
	input  logic fifo_bit,
	input  logic fifo_start,
	output logic take,       // Pop the buffer
	output logic need_data,  // Next bit comes from the buffer
	output logic out_bit,
	output logic out_first,
	output logic out_last,
	output logic out_parity
);

	localparam int MSB = `BCH_ECC_BITS - 1;

	// Counter state after a given number of steps from the seed
	function automatic bch_pkg::count_t count_after(input int steps);
		bch_pkg::count_t c;
		c = bch_pkg::CNT_SEED;
		for (int i = 0; i < steps; i++) begin
			c = bch_pkg::count_step(c);
		end
		return c;
	endfunction

	// The counter is cleared on bit 0 and steps from bit 1 on,
	// so bit i sees the state after i-1 steps
	localparam bch_pkg::count_t SWITCH = count_after(`BCH_K - 2); // Last data bit
	localparam bch_pkg::count_t DONE = count_after(`BCH_N - 2);   // Last parity bit

	bch_pkg::enc_phase_t phase;
	bch_pkg::parity_t parity;
	bch_pkg::parity_t terms;
	bch_pkg::count_t count;
	logic first_bit;
	logic feedback;
	logic count_adv;

	assign need_data = (phase != bch_pkg::PARITY);
	assign take = ce && need_data;
	assign first_bit = take && (phase == bch_pkg::IDLE);

	// Register starts from zero on the first bit
	assign feedback = fifo_bit ^ (parity[MSB] & ~first_bit);
	assign count_adv = ce && (phase != bch_pkg::IDLE);

	lfsr_counter u_counter (
		.clk     (clk),
		.rst_n   (rst_n),
		.clear   (first_bit),
		.advance (count_adv),
		.count   (count)
	);

	lfsr_term #(
		.WIDTH (1)
	) u_terms (
		.in_word (feedback),
		.terms   (terms)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= bch_pkg::IDLE;
		end else begin
			case (phase)
				bch_pkg::IDLE: begin
					if (take) begin
						phase <= bch_pkg::DATA;
					end
				end
				bch_pkg::DATA: begin
					if (take && count == SWITCH) begin
						phase <= bch_pkg::PARITY;
					end
				end
				bch_pkg::PARITY: begin
					if (ce && count == DONE) begin
						phase <= bch_pkg::IDLE; // Back to back start is allowed next
					end
				end
				default: phase <= bch_pkg::IDLE;
			endcase
		end
	end

	// Remainder register is loaded on the first bit of every message
	always_ff @(posedge clk) begin
		if (first_bit) begin
			parity <= terms;
		end else if (take) begin
			parity <= {parity[MSB-1:0], 1'b0} ^ terms;
		end else if (ce) begin
			parity <= {parity[MSB-1:0], 1'b0}; // Shift out with zero fill
		end
	end

	// Data passes straight through in the cycle it is taken
	assign out_bit = need_data ? fifo_bit : parity[MSB];
	assign out_first = first_bit;
	assign out_parity = ce && (phase == bch_pkg::PARITY);
	assign out_last = out_parity && (count == DONE);

	// Flow control must only ask for data that the buffer holds
	a_take_valid: assert property (@(posedge clk) disable iff (!rst_n)
		take |-> fifo_valid);

	// Start marks exactly the first bit of a message
	a_start_framing: assert property (@(posedge clk) disable iff (!rst_n)
		take |-> (fifo_start == (phase == bch_pkg::IDLE)));

endmodule

// ==== source/bch_credit_fifo.sv ====
`timescale 1ns/1ps
`include "bch_settings.svh"

module bch_credit_fifo (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic in_bit,
	input  logic in_start,
	input  logic take,
	output logic fifo_valid,
	output logic fifo_bit,
	output logic fifo_start,
	output logic in_credit
);

	localparam int DEPTH = `BCH_IN_CREDITS;
	localparam int PTR_W = $clog2(DEPTH);

	bch_pkg::word_t mem [DEPTH];
	bch_pkg::word_t head;
	logic [PTR_W:0] wr_ptr; // Extra bit tells full from empty
	logic [PTR_W:0] rd_ptr;
	logic empty;
	logic full;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr[PTR_W-1:0]] <= {in_start, in_bit};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (in_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (take) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	assign head = mem[rd_ptr[PTR_W-1:0]];
	assign fifo_valid = !empty;
	assign fifo_bit = head[0];
	assign fifo_start = head[1];

	// Each freed slot goes straight back upstream
	assign in_credit = take;

	// Upstream sent without a credit
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> !full);

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		take |-> !empty);

endmodule

// ==== source/bch_flow_ctrl.sv ====
`timescale 1ns/1ps
`include "bch_settings.svh"

module bch_flow_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic out_credit, // One more bit may be sent
	input  logic need_data,
	input  logic fifo_valid,
	output logic ce
);

	bch_pkg::credit_t credits;
	logic have_credit;

	assign have_credit = (credits != '0);

	// Parity bits need only a credit, data bits also need a buffered bit
	assign ce = have_credit && (!need_data || fifo_valid);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits <= '0;
		end else if (out_credit && !ce) begin
			credits <= credits + 1'b1;
		end else if (ce && !out_credit) begin
			credits <= credits - 1'b1;
		end
	end

	// Receiver keeps its grants within the limit
	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= `BCH_OUT_CREDITS_MAX);

endmodule

// ==== source/bch_encoder_top.sv ====
`timescale 1ns/1ps

module bch_encoder_top (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic in_bit,
	input  logic in_start,   // First bit of a message
	input  logic out_credit,
	output logic in_credit,
	output logic out_valid,
	output logic out_bit,
	output logic out_first,
	output logic out_last,
	output logic out_parity
);

	logic ce;
	logic take;
	logic need_data;
	logic fifo_valid;
	logic fifo_bit;
	logic fifo_start;

	bch_credit_fifo u_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_bit     (in_bit),
		.in_start   (in_start),
		.take       (take),
		.fifo_valid (fifo_valid),
		.fifo_bit   (fifo_bit),
		.fifo_start (fifo_start),
		.in_credit  (in_credit)
	);

	bch_flow_ctrl u_flow (
		.clk        (clk),
		.rst_n      (rst_n),
		.out_credit (out_credit),
		.need_data  (need_data),
		.fifo_valid (fifo_valid),
		.ce         (ce)
	);

	bch_encode u_encode (
		.clk        (clk),
		.rst_n      (rst_n),
		.ce         (ce),
		.fifo_valid (fifo_valid),
		.fifo_bit   (fifo_bit),
		.fifo_start (fifo_start),
		.take       (take),
		.need_data  (need_data),
		.out_bit    (out_bit),
		.out_first  (out_first),
		.out_last   (out_last),
		.out_parity (out_parity)
	);

	assign out_valid = ce; // Every encoder step emits one bit

endmodule

// ==== testbench/bch_checker.sv ====
`timescale 1ns/1ps
`include "bch_settings.svh"

module bch_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic in_bit,
	input  logic in_start,
	input  logic out_credit,
	input  logic in_credit,
	input  logic out_valid,
	input  logic out_bit,
	input  logic out_first,
	input  logic out_last,
	input  logic out_parity,
	output int   error_count,
	output int   cw_done      // Codewords fully seen
);

	localparam int ECC = `BCH_ECC_BITS;
	localparam logic [ECC:0] GEN = `BCH_GEN_POLY;

	string test_name;
	bit in_bits[$];           // Sent bits not yet seen at the output
	bit in_starts[$];
	int pos;                  // Bit index inside the current codeword
	logic [ECC-1:0] rem;
	logic [ECC-1:0] act_par;
	int up_credits;
	int dn_credits;
	bit credit_seen;
	int checks;
	int tests_run;
	int sent_total;
	int credit_total;
	int test_cw_start;
	int test_check_start;
	int test_err_start;

	initial begin
		error_count = 0;
		checks = 0;
		tests_run = 0;
		sent_total = 0;
		credit_total = 0;
		test_name = "none";
	end

	// Long division by the generator one message bit at a time
	function automatic logic [ECC-1:0] next_remainder(input logic [ECC-1:0] r, input logic d);
		logic fb;
		fb = d ^ r[ECC-1];
		r = {r[ECC-2:0], 1'b0};
		if (fb) begin
			r = r ^ GEN[ECC-1:0]; // x^10 term drops out of the register
		end
		return r;
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			error_count++;
			$display("FAIL %s: %s expected %0h actual %0h", test_name, what, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("ERROR %s: %s", test_name, msg);
	endtask

	task automatic check_quiet();
		check_value("out_valid before any credit", 0, out_valid);
		check_value("out_first before any credit", 0, out_first);
		check_value("out_last before any credit", 0, out_last);
		check_value("in_credit before any credit", 0, in_credit);
	endtask

	task automatic check_bit();
		string where;
		bit d;
		bit s;
		where = $sformatf("codeword %0d bit %0d", cw_done, pos);
		if (pos == 0) begin
			rem = '0;
		end
		check_value({where, " out_first"}, pos == 0, out_first);
		check_value({where, " out_last"}, pos == `BCH_N - 1, out_last);
		check_value({where, " out_parity"}, pos >= `BCH_K, out_parity);
		if (pos < `BCH_K) begin
			if (in_bits.size() == 0) begin
				report_error({where, " came out before its input bit was sent"});
			end else begin
				d = in_bits.pop_front();
				s = in_starts.pop_front();
				check_value({where, " message start"}, pos == 0, s);
				check_value({where, " data"}, d, out_bit);
				rem = next_remainder(rem, d);
			end
		end else begin
			act_par = {act_par[ECC-2:0], out_bit}; // Parity leaves MSB first
		end
		if (pos == `BCH_N - 1) begin
			check_value({where, " parity word"}, rem, act_par);
			cw_done <= cw_done + 1;
			pos = 0;
		end else begin
			pos++;
		end
	endtask

	task automatic track_credits();
		if (out_credit) begin
			credit_seen = 1'b1;
		end
		if (out_valid && dn_credits <= 0) begin
			report_error("out_valid while no output credit was held");
		end
		if (in_valid && up_credits <= 0) begin
			report_error("in_valid sent with no upstream credit left");
		end
		if (out_valid) dn_credits--;
		if (out_credit) dn_credits++; // Usable from the next cycle on
		if (in_valid) begin
			up_credits--;
			sent_total++;
		end
		if (in_credit) begin
			up_credits++;
			credit_total++;
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			pos = 0;
			rem = '0;
			act_par = '0;
			in_bits.delete();
			in_starts.delete();
			up_credits = `BCH_IN_CREDITS;
			dn_credits = 0;
			credit_seen = 1'b0;
			cw_done <= 0;
		end else begin
			if (!credit_seen) begin
				check_quiet();
			end
			if (out_valid) begin
				check_bit();
			end else if (out_first || out_last || out_parity) begin
				report_error("framing flag raised without out_valid");
			end
			track_credits();
			if (in_valid) begin
				in_bits.push_back(in_bit);
				in_starts.push_back(in_start);
			end
		end
	end

	task automatic begin_test(input string name);
		test_name = name;
		test_cw_start = cw_done;
		test_check_start = checks;
		test_err_start = error_count;
	endtask

	task automatic end_test();
		if (pos != 0 || in_bits.size() != 0) begin
			report_error("a message was left unfinished at the end of the test");
		end
		check_value("in_credit pulses against bits sent", sent_total, credit_total);
		tests_run++;
		$display("test %-16s %0d codewords, %0d checks, %0d errors", test_name,
			cw_done - test_cw_start, checks - test_check_start, error_count - test_err_start);
	endtask

	task automatic print_summary();
		$display("%0d tests, %0d codewords, %0d checks, %0d errors",
			tests_run, cw_done, checks, error_count);
	endtask

endmodule

// ==== testbench/bch_tb.sv ====
`timescale 1ns/1ps
`include "bch_settings.svh"

module bch_tb;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_bit;
	logic in_start;
	logic out_credit;
	logic in_credit;
	logic out_valid;
	logic out_bit;
	logic out_first;
	logic out_last;
	logic out_parity;

	integer seed = 32'h4fe0b68b;
	bit tx_bits[$];       // Bits waiting for an upstream credit
	bit tx_starts[$];
	int msgs_pushed;
	int up_credits;
	int outstanding;      // Output credits granted and not yet used
	int grant_rate;       // Grant chance in quarters
	logic stall;
	logic aborted;
	int chk_errors;
	int cw_done;

	bch_encoder_top uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_bit     (in_bit),
		.in_start   (in_start),
		.out_credit (out_credit),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_bit    (out_bit),
		.out_first  (out_first),
		.out_last   (out_last),
		.out_parity (out_parity)
	);

	bch_checker chk (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_bit      (in_bit),
		.in_start    (in_start),
		.out_credit  (out_credit),
		.in_credit   (in_credit),
		.out_valid   (out_valid),
		.out_bit     (out_bit),
		.out_first   (out_first),
		.out_last    (out_last),
		.out_parity  (out_parity),
		.error_count (chk_errors),
		.cw_done     (cw_done)
	);

	always #10 clk = ~clk;

	// Upstream sender and downstream receiver share one process
	always @(posedge clk) begin : drive_links
		integer r_send;
		integer r_grant;
		logic live;
		live = rst_n;
		if (!live) begin
			up_credits = `BCH_IN_CREDITS;
			outstanding = 0;
		end else begin
			if (in_valid) up_credits--;
			if (in_credit) up_credits++;
			if (out_credit) outstanding++;
			if (out_valid) outstanding--;
		end
		#2;
		r_send = $random(seed);
		r_grant = $random(seed);
		in_valid = 1'b0;
		in_bit = 1'b0;
		in_start = 1'b0;
		if (live && up_credits > 0 && tx_bits.size() > 0 && r_send[1:0] != 2'b00) begin
			in_valid = 1'b1;
			in_bit = tx_bits.pop_front();
			in_start = tx_starts.pop_front();
		end
		out_credit = live && !stall && outstanding < `BCH_OUT_CREDITS_MAX &&
			(r_grant[1:0] < grant_rate);
	end

	task automatic push_message(input logic [`BCH_K-1:0] msg);
		for (int i = `BCH_K - 1; i >= 0; i--) begin
			tx_bits.push_back(msg[i]);
			tx_starts.push_back(i == `BCH_K - 1);
		end
		msgs_pushed++;
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (!aborted && (tx_bits.size() != 0 || cw_done != msgs_pushed)) begin
			@(posedge clk);
			n++;
			if (n >= limit) begin
				$display("Timeout: %0d codewords still missing after %0d cycles",
					msgs_pushed - cw_done, limit);
				aborted = 1'b1;
			end
		end
	endtask

	task automatic wait_credits_spent(input int limit);
		int n;
		n = 0;
		while (!aborted && outstanding != 0) begin
			@(negedge clk); // Credit count settles on the rising edge
			n++;
			if (n >= limit) begin
				$display("Timeout: output credits were not used up within %0d cycles", limit);
				aborted = 1'b1;
			end
		end
	endtask

	task automatic start_phase(input string name);
		@(negedge clk);
		chk.begin_test(name);
		@(posedge clk);
	endtask

	task automatic end_phase();
		@(negedge clk);
		chk.end_test();
	endtask

	initial begin : main
		logic [`BCH_K-1:0] msg;
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_bit = 1'b0;
		in_start = 1'b0;
		out_credit = 1'b0;
		stall = 1'b0;
		aborted = 1'b0;
		grant_rate = 0;
		msgs_pushed = 0;

		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		start_phase("reset");
		repeat (20) @(posedge clk); // No credits yet, so nothing may move
		end_phase();

		start_phase("single_messages");
		grant_rate = 2;
		push_message('0);
		wait_drained(400);
		push_message('1);
		wait_drained(400);
		for (int i = 0; i < 6; i++) begin
			msg = $random(seed);
			push_message(msg);
			wait_drained(400);
		end
		end_phase();

		start_phase("back_to_back");
		grant_rate = 4;
		for (int i = 0; i < 12; i++) begin
			msg = $random(seed);
			push_message(msg);
		end
		wait_drained(1500);
		end_phase();

		start_phase("output_stall");
		grant_rate = 3;
		for (int i = 0; i < 6; i++) begin
			msg = $random(seed);
			push_message(msg);
		end
		repeat (40) @(posedge clk);
		stall = 1'b1;
		wait_credits_spent(100);
		repeat (200) @(posedge clk);
		stall = 1'b0;
		wait_drained(1500);
		end_phase();

		@(negedge clk);
		chk.print_summary();
		if (!aborted && chk_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+source
source/bch_pkg.sv
source/lfsr_counter.sv
source/lfsr_term.sv
source/bch_encode.sv
source/bch_credit_fifo.sv
source/bch_flow_ctrl.sv
source/bch_encoder_top.sv
testbench/bch_checker.sv
testbench/bch_tb.sv
